/* list.f */
+incdir+src
src/kem_cmd_pkg.sv
src/core_bus_pkg.sv
src/kem_phase_sequencer.sv
src/phase_flattener.sv
src/step_sequencer.sv
src/core_cmd_expander.sv
src/kem_control_top.sv
verif/kem_control_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := kem_control_tb
FILE_LIST := list.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILE_LIST)) src/frodo_config.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/kem_control_tb.sv */
`default_nettype none

`include "frodo_config.svh"

module kem_control_tb
  import kem_cmd_pkg::*, core_bus_pkg::*;
();

  localparam int ROWS = 8;

  // Fields of one predicted core command
  typedef struct packed {
    core_which_t which;
    hub_mask_t   dst;
    hub_mask_t   src;
    mem_cmd_e    mem;
    logic        is_kib;
    logic [7:0]  kbyte;
    word_cnt_t   in_w;
    word_cnt_t   out_w;
  } expected_t;

  logic        clk = 1'b0;
  logic        i_rst_n;
  host_cmd_e   i_cmd;
  logic        i_cmd_valid;
  logic        o_cmd_ready;
  core_cmd_t   o_core_cmd;
  core_which_t o_core_which;
  logic        i_core_consume;

  expected_t   exp_q[$];
  expected_t   exp_head;
  int          exp_left;
  int          cycles;
  int          limit;
  integer      seed = 5;
  logic        offered;
  logic        fire;

  kem_control_top #(
    .GENA_ROWS (ROWS)
  ) dut0 (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_cmd          (i_cmd),
    .i_cmd_valid    (i_cmd_valid),
    .o_cmd_ready    (o_cmd_ready),
    .o_core_cmd     (o_core_cmd),
    .o_core_which   (o_core_which),
    .i_core_consume (i_core_consume)
  );

  always #10 clk = ~clk;

  assign offered = (o_core_which != '0);
  assign fire    = offered & i_core_consume;

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] want);
    $display("Mismatch %s: got 0x%h, expected 0x%h", sig, got, want);
    abort_run();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic push_step(input exp_kind_e kind, input hub_mask_t src, input hub_mask_t dst,
                           input mem_cmd_e mem, input logic [7:0] kbyte);
    expected_t e;
    e = '0;
    e.dst = dst;
    e.src = src;
    e.mem = mem;
    e.kbyte = kbyte;
    e.is_kib = (kind == EXP_KI_BYTE);
    if (kind == EXP_GEN_A_K_OUT) begin
      e.which.k     = 1'b1;
      e.which.k_in  = 1'b1;
      e.which.k_out = 1'b1;
    end else begin
      // Hub bits from 0 up are keccak, outer, mem_and_mul and seed_a
      if (dst[0]) e.which.k_in = 1'b1;
      if (src[0]) e.which.k_out = 1'b1;
      if (dst[1]) e.which.o_out = 1'b1;
      if (src[1]) e.which.o_in = 1'b1;
      if (dst[2] || src[2]) e.which.m = 1'b1;
      if (dst[3] || src[3]) e.which.s = 1'b1;
      if (dst != '0 || src != '0) e.which.k = 1'b1;
      // Units selected by the step kind alone
      case (kind)
        EXP_KI_BYTE: e.which.k_in = 1'b1;
        EXP_M:       e.which.m = 1'b1;
        EXP_GENERIC: ;
        default:     e.which.k = 1'b1;
      endcase
    end
    // Only the two exact outer/keccak moves carry word counts
    if (src == HUB_OUTER && dst == HUB_KECCAK) e.in_w = word_cnt_t'(`FRODO_KIN_WORDS);
    if (src == HUB_KECCAK && dst == HUB_OUTER) e.out_w = word_cnt_t'(`FRODO_KOUT_WORDS);
    exp_q.push_back(e);
  endtask

  task automatic op_step(input exp_kind_e kind, input logic [7:0] kbyte);
    push_step(kind, '0, '0, MEM_NONE, kbyte);
  endtask

  task automatic move_step(input hub_mask_t src, input hub_mask_t dst, input mem_cmd_e mem);
    push_step(EXP_GENERIC, src, dst, mem, 8'h00);
  endtask

  task automatic setup_test_items();
    move_step(HUB_OUTER, HUB_MEM, MEM_IN_SEED_SE);
    move_step(HUB_OUTER, HUB_MEM, MEM_IN_U);
    move_step(HUB_OUTER, HUB_MEM, MEM_IN_SALT);
    move_step(HUB_OUTER, HUB_SEED_A, MEM_NONE);
  endtask

  task automatic add_entropy_items();
    op_step(EXP_K_SINGLE, 8'h00);
    op_step(EXP_KI_BYTE, 8'h05);
    move_step(HUB_MEM, HUB_KECCAK, MEM_OUT_RNG_STATE);
    move_step(HUB_OUTER, HUB_KECCAK, MEM_NONE);
    move_step(HUB_KECCAK, HUB_MEM, MEM_IN_RNG_STATE);
  endtask

  task automatic keygen_items(input logic test_mode);
    row_idx_t row;
    if (test_mode) begin
      move_step(HUB_MEM, HUB_OUTER, MEM_OUT_U);
    end else begin
      op_step(EXP_KI_BYTE, 8'h00);
      move_step(HUB_MEM, HUB_KECCAK, MEM_OUT_RNG_STATE);
      op_step(EXP_K_SINGLE, 8'h00);
      move_step(HUB_KECCAK, HUB_OUTER, MEM_NONE);
      move_step(HUB_KECCAK, HUB_MEM, MEM_IN_SEED_SE);
      move_step(HUB_KECCAK, HUB_SEED_A, MEM_NONE);
      op_step(EXP_K_SINGLE, 8'h00);
      op_step(EXP_KI_BYTE, 8'h01);
      move_step(HUB_MEM, HUB_KECCAK, MEM_OUT_RNG_STATE);
      move_step(HUB_KECCAK, HUB_MEM, MEM_IN_RNG_STATE);
    end
    // Sampling of S and E, then seed_a
    op_step(EXP_K_LONG_OUT, 8'h00);
    op_step(EXP_KI_BYTE, 8'h5f);
    move_step(HUB_MEM, HUB_KECCAK, MEM_OUT_SEED_SE);
    move_step(HUB_KECCAK, HUB_MEM | HUB_OUTER, MEM_IN_S_ROW_FIRST);
    move_step(HUB_KECCAK, HUB_MEM, MEM_IN_B_COL_FIRST);
    op_step(EXP_K_SINGLE, 8'h00);
    move_step(HUB_SEED_A, HUB_KECCAK, MEM_NONE);
    move_step(HUB_KECCAK, HUB_SEED_A | HUB_OUTER, MEM_NONE);
    op_step(EXP_K_NO_OVERLAP, 8'h00);
    push_step(EXP_M, '0, '0, MEM_IN_OP_B_PLEQ_S_TIMES_IN_AT, 8'h00);
    for (int r = 0; r < ROWS; r++) begin
      row = row_idx_t'(r);
      op_step(EXP_KI_BYTE, row[7:0]);
      op_step(EXP_KI_BYTE, row[15:8]);
      move_step(HUB_SEED_A, HUB_KECCAK, MEM_NONE);
      push_step(EXP_GEN_A_K_OUT, HUB_KECCAK, HUB_MEM, MEM_NONE, 8'h00);
    end
    op_step(EXP_K_NO_OVERLAP, 8'h00);
    op_step(EXP_K_LONG_IN, 8'h00);
    move_step(HUB_SEED_A, HUB_KECCAK, MEM_NONE);
    move_step(HUB_MEM, HUB_KECCAK | HUB_OUTER, MEM_OUT_B_COL_FIRST);
    move_step(HUB_KECCAK, HUB_OUTER, MEM_NONE);
    push_step(EXP_M, '0, '0, MEM_OP_ERASE1, 8'h00);
  endtask

  // Called 2 units after an edge with o_cmd_ready high
  task automatic issue_command(input host_cmd_e cmd);
    i_cmd = cmd;
    i_cmd_valid = 1'b1;
    @(posedge clk);
    #2;
    i_cmd_valid = 1'b0;
    while (!o_cmd_ready) begin
      @(posedge clk);
      #2;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks on the core bus
  ////////////////////////////////////////////////////////////////////////////

  a_no_extra: assert property (@(posedge clk) disable iff (!i_rst_n) fire |-> exp_left != 0)
    else begin
      $display("DUT offered a core command after the expected sequence ended");
      abort_run();
    end

  a_which: assert property (@(posedge clk) disable iff (!i_rst_n)
    fire |-> o_core_which == exp_head.which)
    else mismatch("o_core_which", 32'($sampled(o_core_which)), 32'($sampled(exp_head.which)));

  a_dst: assert property (@(posedge clk) disable iff (!i_rst_n)
    fire |-> o_core_cmd.h_dst == exp_head.dst)
    else mismatch("o_core_cmd.h_dst", 32'($sampled(o_core_cmd.h_dst)),
                  32'($sampled(exp_head.dst)));

  a_src: assert property (@(posedge clk) disable iff (!i_rst_n)
    fire |-> o_core_cmd.h_src == exp_head.src)
    else mismatch("o_core_cmd.h_src", 32'($sampled(o_core_cmd.h_src)),
                  32'($sampled(exp_head.src)));

  a_mem: assert property (@(posedge clk) disable iff (!i_rst_n)
    fire |-> o_core_cmd.mem_cmd == exp_head.mem)
    else mismatch("o_core_cmd.mem_cmd", 32'($sampled(o_core_cmd.mem_cmd)),
                  32'($sampled(exp_head.mem)));

  a_kin_byte: assert property (@(posedge clk) disable iff (!i_rst_n)
    (fire && exp_head.is_kib) |-> o_core_cmd.k_in_byte == exp_head.kbyte)
    else mismatch("o_core_cmd.k_in_byte", 32'($sampled(o_core_cmd.k_in_byte)),
                  32'($sampled(exp_head.kbyte)));

  a_in_words: assert property (@(posedge clk) disable iff (!i_rst_n)
    fire |-> o_core_cmd.o_in_words == exp_head.in_w)
    else mismatch("o_core_cmd.o_in_words", 32'($sampled(o_core_cmd.o_in_words)),
                  32'($sampled(exp_head.in_w)));

  a_out_words: assert property (@(posedge clk) disable iff (!i_rst_n)
    fire |-> o_core_cmd.o_out_words == exp_head.out_w)
    else mismatch("o_core_cmd.o_out_words", 32'($sampled(o_core_cmd.o_out_words)),
                  32'($sampled(exp_head.out_w)));

  a_held: assert property (@(posedge clk) disable iff (!i_rst_n)
    (offered && !i_core_consume) |=> ($stable(o_core_cmd) && $stable(o_core_which)))
    else begin
      $display("Core command changed or vanished before it was consumed");
      abort_run();
    end

  // Queue head advances on every consumed command
  always @(posedge clk) begin
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, %0d commands still expected", cycles, exp_left);
      abort_run();
    end else begin
      cycles <= cycles + 1;
      if (i_rst_n && fire && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
        exp_left <= exp_q.size();
      end
    end
  end

  always @(posedge clk) begin
    #2;
    i_core_consume = (($random(seed) & 3) != 0);
  end

  initial begin
    i_rst_n        = 1'b0;
    i_cmd          = CMD_KEYGEN;
    i_cmd_valid    = 1'b0;
    i_core_consume = 1'b0;
    setup_test_items();
    keygen_items(1'b1);
    add_entropy_items();
    keygen_items(1'b0);
    cycles   <= 0;
    exp_head <= exp_q[0];
    exp_left <= exp_q.size();
    limit    = 4 * exp_q.size() + 200;

    repeat (8) @(posedge clk);
    #2;
    i_rst_n = 1'b1;
    assert (o_cmd_ready == 1'b1)
      else mismatch("o_cmd_ready", 32'(o_cmd_ready), 32'd1);
    assert (o_core_which == '0)
      else mismatch("o_core_which", 32'(o_core_which), 32'd0);

    issue_command(CMD_SETUP_TEST);
    issue_command(CMD_KEYGEN);
    issue_command(CMD_ADD_ENTROPY);
    issue_command(CMD_KEYGEN);

    // Last table of the final command drains after the host port is ready
    while (!(o_cmd_ready && o_core_which == '0)) begin
      @(posedge clk);
      #2;
    end

    if (exp_left == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("Commands finished with %0d expected core commands never offered", exp_left);
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* src/kem_control_top.sv */
`default_nettype none

`include "frodo_config.svh"

module kem_control_top import kem_cmd_pkg::*, core_bus_pkg::*; #(
  parameter int GENA_ROWS = `FRODO_GENA_ROWS
) (
  input  wire logic      clk,
  input  wire logic      i_rst_n,
  input  wire host_cmd_e i_cmd,
  input  wire logic      i_cmd_valid,
  output logic           o_cmd_ready,
  output core_cmd_t      o_core_cmd,
  output core_which_t    o_core_which,
  input  wire logic      i_core_consume
);

  // Phase link
  phase_item_t phase;
  logic        phase_valid;
  logic        phase_consume;

  // Table start link
  step_table_e table_sel;
  logic        tbl_start;
  logic        tbl_can_start;
  row_idx_t    row;

  // Step link
  step_item_t  step;
  logic        step_has_any;
  logic        step_consume;

  kem_phase_sequencer u_phase_seq (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_cmd           (i_cmd),
    .i_cmd_valid     (i_cmd_valid),
    .o_cmd_ready     (o_cmd_ready),
    .o_phase         (phase),
    .o_phase_valid   (phase_valid),
    .i_phase_consume (phase_consume)
  );

  phase_flattener #(
    .GENA_ROWS (GENA_ROWS)
  ) u_flattener (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_phase         (phase),
    .i_phase_valid   (phase_valid),
    .o_phase_consume (phase_consume),
    .o_table         (table_sel),
    .o_start         (tbl_start),
    .i_can_start     (tbl_can_start),
    .o_row           (row)
  );

  step_sequencer u_step_seq (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_table     (table_sel),
    .i_start     (tbl_start),
    .o_can_start (tbl_can_start),
    .i_row       (row),
    .o_step      (step),
    .o_has_any   (step_has_any),
    .i_consume   (step_consume)
  );

  core_cmd_expander u_expander (
    .i_step         (step),
    .i_has_any      (step_has_any),
    .o_consume      (step_consume),
    .o_core_cmd     (o_core_cmd),
    .o_core_which   (o_core_which),
    .i_core_consume (i_core_consume)
  );

endmodule

`default_nettype wire

/* src/core_cmd_expander.sv */
`default_nettype none

`include "frodo_config.svh"

module core_cmd_expander import core_bus_pkg::*; (
  input  wire step_item_t i_step,
  input  wire logic       i_has_any,
  output logic            o_consume,
  output core_cmd_t       o_core_cmd,
  output core_which_t     o_core_which,
  input  wire logic       i_core_consume
);

  hub_mask_t   hub_any;
  core_which_t which;
  logic        k_kind;

  assign hub_any   = i_step.h_dst | i_step.h_src;
  assign k_kind    = i_step.kind inside {EXP_K_SINGLE, EXP_K_LONG_IN, EXP_K_LONG_OUT,
                                         EXP_K_NO_OVERLAP};
  assign o_consume = i_core_consume;

  ////////////////////////////////////////////////////////////////////////////
  // Unit select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    which = '0;
    if (i_step.kind == EXP_GEN_A_K_OUT) begin
      which.k     = 1'b1;
      which.k_in  = 1'b1;
      which.k_out = 1'b1;
    end else begin
      which.k_in  = (|(i_step.h_dst & HUB_KECCAK)) | (i_step.kind == EXP_KI_BYTE);
      which.k_out = |(i_step.h_src & HUB_KECCAK);
      which.o_out = |(i_step.h_dst & HUB_OUTER);
      which.o_in  = |(i_step.h_src & HUB_OUTER);
      which.m     = (|(hub_any & HUB_MEM)) | (i_step.kind == EXP_M);
      which.s     = |(hub_any & HUB_SEED_A);
      which.k     = (hub_any != '0) | k_kind;
    end
  end

  assign o_core_which = i_has_any ? which : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Command fields
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    o_core_cmd = '0;

    // Outer port word counts for the two fixed-size moves
    if (i_step.h_dst == HUB_KECCAK && i_step.h_src == HUB_OUTER) begin
      o_core_cmd.o_in_words = word_cnt_t'(`FRODO_KIN_WORDS);
    end
    if (i_step.h_dst == HUB_OUTER && i_step.h_src == HUB_KECCAK) begin
      o_core_cmd.o_out_words = word_cnt_t'(`FRODO_KOUT_WORDS);
    end

    o_core_cmd.k_in_byte      = i_step.param[7:0];
    o_core_cmd.k_in_not_last  = ~i_step.k_is_last;
    o_core_cmd.k_in_mode      = (i_step.kind == EXP_KI_BYTE) ? KI_SEND_BYTE : KI_FORWARD;
    o_core_cmd.k_out_not_last = ~i_step.k_is_last;
    o_core_cmd.k_out_sampled  = i_step.k_is_sampled;
    o_core_cmd.h_dst          = i_step.h_dst;
    o_core_cmd.h_src          = i_step.h_src;
    o_core_cmd.is_pack        = i_step.is_pack;
    o_core_cmd.mem_cmd        = i_step.mem_cmd;
    o_core_cmd.s              = |(i_step.h_dst & HUB_SEED_A);

    // Hash unit run mode and block count
    case (i_step.kind)
      EXP_GEN_A_K_OUT: begin
        o_core_cmd.k_mode  = 4'b1000;
        o_core_cmd.k_count = 9'd16;
        o_core_cmd.k_en    = 1'b1;
      end
      EXP_K_SINGLE: begin
        o_core_cmd.k_count = 9'd1;
        o_core_cmd.k_en    = 1'b1;
      end
      EXP_K_LONG_IN: begin
        o_core_cmd.k_mode  = 4'b0001;
        o_core_cmd.k_count = i_step.param;
        o_core_cmd.k_en    = 1'b1;
      end
      EXP_K_LONG_OUT: begin
        o_core_cmd.k_count = i_step.param;
        o_core_cmd.k_en    = 1'b1;
      end
      default: begin
        // no_overlap leaves the hash unit disabled as well
        o_core_cmd.k_en = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/step_sequencer.sv */
`default_nettype none

`include "frodo_config.svh"

module step_sequencer import kem_cmd_pkg::*, core_bus_pkg::*; (
  input  wire logic        clk,
  input  wire logic        i_rst_n,
  input  wire step_table_e i_table,
  input  wire logic        i_start,
  output logic             o_can_start,
  input  wire row_idx_t    i_row,
  output step_item_t       o_step,
  output logic             o_has_any,
  input  wire logic        i_consume
);

  localparam int MAX_STEPS = `FRODO_MAX_STEPS;

  typedef logic [$clog2(MAX_STEPS+1)-1:0] len_t;

  step_table_e          table_q;
  logic [MAX_STEPS-1:0] state;
  len_t                 len_q;
  logic                 busy;
  logic                 last_step;
  int                   idx;

  function automatic len_t table_len(step_table_e sel);
    len_t n;
    case (sel)
      TBL_GEN_A_ITER:        n = 4;
      TBL_KEYGEN_PRNG:       n = 10;
      TBL_KEYGEN_NO_PRNG:    n = 1;
      TBL_KEYGEN_MID:        n = 10;
      TBL_KEYGEN_POST_GEN_A: n = 6;
      TBL_SETUP_TEST:        n = 4;
      default:               n = 5;
    endcase
    return n;
  endfunction

  // Step without a hub move
  function automatic step_item_t op(exp_kind_e kind, param_t param,
                                    mem_cmd_e mem = MEM_NONE);
    return '{kind, 1'b0, 1'b0, param, mem, 1'b0, 4'b0000, 4'b0000};
  endfunction

  // Hub move from src to dst
  function automatic step_item_t mv(hub_mask_t src, hub_mask_t dst, mem_cmd_e mem,
                                    logic last, logic sampled = 1'b0, logic pack = 1'b0);
    return '{EXP_GENERIC, last, sampled, '0, mem, pack, dst, src};
  endfunction

  assign o_can_start = ~busy;
  assign o_has_any   = busy;
  assign last_step   = (idx == int'(len_q) - 1);

  always_comb begin
    idx = 0;
    for (int i = 0; i < MAX_STEPS; i++) begin
      if (state[i]) idx = i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Step tables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    o_step = op(EXP_GENERIC, '0);
    case (table_q)
      TBL_GEN_A_ITER:
        case (idx)
          // One row of A, seeded with the row index and seed_a
          0: o_step = op(EXP_KI_BYTE, {1'b0, i_row[7:0]});
          1: o_step = op(EXP_KI_BYTE, {1'b0, i_row[15:8]});
          2: o_step = mv(HUB_SEED_A, HUB_KECCAK, MEM_NONE, 1'b1);
          default: o_step = '{EXP_GEN_A_K_OUT, 1'b1, 1'b0, '0, MEM_NONE, 1'b0,
                              HUB_MEM, HUB_KECCAK};
        endcase
      TBL_KEYGEN_PRNG:
        case (idx)
          // Secret s, seed_se and z from the RNG state
          0: o_step = op(EXP_KI_BYTE, 9'h000);
          1: o_step = mv(HUB_MEM, HUB_KECCAK, MEM_OUT_RNG_STATE, 1'b1);
          2: o_step = op(EXP_K_SINGLE, '0);
          3: o_step = mv(HUB_KECCAK, HUB_OUTER, MEM_NONE, 1'b0);
          4: o_step = mv(HUB_KECCAK, HUB_MEM, MEM_IN_SEED_SE, 1'b0);
          5: o_step = mv(HUB_KECCAK, HUB_SEED_A, MEM_NONE, 1'b1);
          // Refresh the RNG state
          6: o_step = op(EXP_K_SINGLE, '0);
          7: o_step = op(EXP_KI_BYTE, 9'h001);
          8: o_step = mv(HUB_MEM, HUB_KECCAK, MEM_OUT_RNG_STATE, 1'b1);
          default: o_step = mv(HUB_KECCAK, HUB_MEM, MEM_IN_RNG_STATE, 1'b1);
        endcase
      TBL_KEYGEN_NO_PRNG: o_step = mv(HUB_MEM, HUB_OUTER, MEM_OUT_U, 1'b0);
      TBL_KEYGEN_MID:
        case (idx)
          // Sample S and E from seed_se
          0: o_step = op(EXP_K_LONG_OUT, 9'd317);
          1: o_step = op(EXP_KI_BYTE, 9'h05f);
          2: o_step = mv(HUB_MEM, HUB_KECCAK, MEM_OUT_SEED_SE, 1'b1);
          3: o_step = mv(HUB_KECCAK, HUB_MEM | HUB_OUTER, MEM_IN_S_ROW_FIRST, 1'b0, 1'b1);
          4: o_step = mv(HUB_KECCAK, HUB_MEM, MEM_IN_B_COL_FIRST, 1'b1, 1'b1);
          // seed_a from z, also sent out
          5: o_step = op(EXP_K_SINGLE, '0);
          6: o_step = mv(HUB_SEED_A, HUB_KECCAK, MEM_NONE, 1'b1);
          7: o_step = mv(HUB_KECCAK, HUB_SEED_A | HUB_OUTER, MEM_NONE, 1'b1);
          8: o_step = op(EXP_K_NO_OVERLAP, '0);
          default: o_step = op(EXP_M, '0, MEM_IN_OP_B_PLEQ_S_TIMES_IN_AT);
        endcase
      TBL_KEYGEN_POST_GEN_A:
        case (idx)
          // Packed b goes out and into pkh
          0: o_step = op(EXP_K_NO_OVERLAP, '0);
          1: o_step = op(EXP_K_LONG_IN, 9'd159);
          2: o_step = mv(HUB_SEED_A, HUB_KECCAK, MEM_NONE, 1'b0);
          3: o_step = mv(HUB_MEM, HUB_KECCAK | HUB_OUTER, MEM_OUT_B_COL_FIRST, 1'b1, 1'b0, 1'b1);
          4: o_step = mv(HUB_KECCAK, HUB_OUTER, MEM_NONE, 1'b1);
          default: o_step = op(EXP_M, '0, MEM_OP_ERASE1);
        endcase
      TBL_SETUP_TEST:
        case (idx)
          0: o_step = mv(HUB_OUTER, HUB_MEM, MEM_IN_SEED_SE, 1'b0);
          1: o_step = mv(HUB_OUTER, HUB_MEM, MEM_IN_U, 1'b0);
          2: o_step = mv(HUB_OUTER, HUB_MEM, MEM_IN_SALT, 1'b0);
          default: o_step = mv(HUB_OUTER, HUB_SEED_A, MEM_NONE, 1'b0);
        endcase
      default:
        case (idx)
          // Host entropy mixed into the RNG state
          0: o_step = op(EXP_K_SINGLE, '0);
          1: o_step = op(EXP_KI_BYTE, 9'h005);
          2: o_step = mv(HUB_MEM, HUB_KECCAK, MEM_OUT_RNG_STATE, 1'b0);
          3: o_step = mv(HUB_OUTER, HUB_KECCAK, MEM_NONE, 1'b1);
          default: o_step = mv(HUB_KECCAK, HUB_MEM, MEM_IN_RNG_STATE, 1'b1);
        endcase
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      busy    <= 1'b0;
      state   <= '0;
      table_q <= TBL_GEN_A_ITER;
      len_q   <= '0;
    end else if (i_start && !busy) begin
      busy    <= 1'b1;
      state   <= {{(MAX_STEPS-1){1'b0}}, 1'b1};
      table_q <= i_table;
      len_q   <= table_len(i_table);
    end else if (busy && i_consume) begin
      if (last_step) begin
        busy <= 1'b0;
      end else begin
        state <= state << 1;
      end
    end
  end

  // Row index from the flattener must hold for the whole table too
  a_step_stable: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (o_has_any && !i_consume) |=> (o_has_any && $stable(o_step))
  );

endmodule

`default_nettype wire

/* src/phase_flattener.sv */
`default_nettype none

`include "frodo_config.svh"

module phase_flattener import kem_cmd_pkg::*, core_bus_pkg::*; #(
  parameter int GENA_ROWS = `FRODO_GENA_ROWS
) (
  input  wire logic        clk,
  input  wire logic        i_rst_n,
  input  wire phase_item_t i_phase,
  input  wire logic        i_phase_valid,
  output logic             o_phase_consume,
  output step_table_e      o_table,
  output logic             o_start,
  input  wire logic        i_can_start,
  output row_idx_t         o_row
);

  localparam row_idx_t LAST_ROW = row_idx_t'(GENA_ROWS - 1);

  row_idx_t row_cnt;
  logic     is_gen_a;
  logic     last_row;

  assign is_gen_a = (i_phase.phase == PH_GEN_A);
  assign last_row = (row_cnt == LAST_ROW);
  assign o_start  = i_phase_valid & i_can_start;

  // Matrix A phase stays put until its final row has started
  assign o_phase_consume = o_start & (~is_gen_a | last_row);

  always_comb begin
    case (i_phase.phase)
      PH_GEN_A:             o_table = TBL_GEN_A_ITER;
      PH_KEYGEN_PRNG:       o_table = i_phase.is_test ? TBL_KEYGEN_NO_PRNG : TBL_KEYGEN_PRNG;
      PH_KEYGEN_MID:        o_table = TBL_KEYGEN_MID;
      PH_KEYGEN_POST_GEN_A: o_table = TBL_KEYGEN_POST_GEN_A;
      PH_ADD_ENTROPY:       o_table = TBL_ADD_ENTROPY;
      default:              o_table = TBL_SETUP_TEST;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      row_cnt <= '0;
    end else if (o_start && is_gen_a) begin
      row_cnt <= last_row ? '0 : row_cnt + 1'b1;
    end
  end

  // Row seen by the table that just started
  always_ff @(posedge clk) begin
    if (o_start) begin
      o_row <= row_cnt;
    end
  end

  a_row_in_range: assert property (
    @(posedge clk) disable iff (!i_rst_n) int'(row_cnt) < GENA_ROWS
  );

endmodule

`default_nettype wire

/* src/kem_phase_sequencer.sv */
`default_nettype none

module kem_phase_sequencer import kem_cmd_pkg::*; (
  input  wire logic        clk,
  input  wire logic        i_rst_n,
  input  wire host_cmd_e   i_cmd,
  input  wire logic        i_cmd_valid,
  output logic             o_cmd_ready,
  output phase_item_t      o_phase,
  output logic             o_phase_valid,
  input  wire logic        i_phase_consume
);

  localparam int N_PHASES = 4;

  host_cmd_e           cmd_q;
  logic [N_PHASES-1:0] state;
  logic                busy;
  logic                test_flag;
  logic                is_test_q;
  logic                cmd_fire;
  logic                phase_fire;
  logic                last_phase;

  assign o_cmd_ready   = ~busy;
  assign o_phase_valid = busy;
  assign cmd_fire      = i_cmd_valid & o_cmd_ready;
  assign phase_fire    = o_phase_valid & i_phase_consume;
  assign last_phase    = (cmd_q == CMD_KEYGEN) ? state[N_PHASES-1] : state[0];

  // Phase list of the running command
  always_comb begin
    o_phase.is_test = is_test_q;
    case (cmd_q)
      CMD_KEYGEN: begin
        case (1'b1)
          state[1]: o_phase.phase = PH_KEYGEN_MID;
          state[2]: o_phase.phase = PH_GEN_A;
          state[3]: o_phase.phase = PH_KEYGEN_POST_GEN_A;
          default:  o_phase.phase = PH_KEYGEN_PRNG;
        endcase
      end
      CMD_ADD_ENTROPY: o_phase.phase = PH_ADD_ENTROPY;
      default:         o_phase.phase = PH_SETUP_TEST;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      busy      <= 1'b0;
      state     <= '0;
      cmd_q     <= CMD_KEYGEN;
      test_flag <= 1'b0;
      is_test_q <= 1'b0;
    end else if (cmd_fire) begin
      busy      <= 1'b1;
      state     <= {{(N_PHASES-1){1'b0}}, 1'b1};
      cmd_q     <= i_cmd;
      // flag describes the previous command, so it moves on first
      test_flag <= (i_cmd == CMD_SETUP_TEST);
      is_test_q <= test_flag;
    end else if (phase_fire) begin
      if (last_phase) begin
        busy <= 1'b0;
      end else begin
        state <= state << 1;
      end
    end
  end

  // Host keeps valid low while a command is still running
  a_cmd_only_when_ready: assert property (
    @(posedge clk) disable iff (!i_rst_n) i_cmd_valid |-> o_cmd_ready
  );

endmodule

`default_nettype wire

/* src/core_bus_pkg.sv */
`default_nettype none

`include "frodo_config.svh"

package core_bus_pkg;

  typedef logic [`FRODO_PARAM_W-1:0] param_t;
  typedef logic [`FRODO_ROW_W-1:0]   row_idx_t;
  typedef logic [3:0]                hub_mask_t;
  typedef logic [14:0]               word_cnt_t;
  typedef logic [3:0]                k_mode_t;

  // Hub endpoints, one bit each
  localparam hub_mask_t HUB_KECCAK = 4'b0001;
  localparam hub_mask_t HUB_OUTER  = 4'b0010;
  localparam hub_mask_t HUB_MEM    = 4'b0100;
  localparam hub_mask_t HUB_SEED_A = 4'b1000;

  typedef enum logic [4:0] {
    MEM_NONE,
    MEM_OUT_RNG_STATE,
    MEM_IN_RNG_STATE,
    MEM_IN_SEED_SE,
    MEM_OUT_SEED_SE,
    MEM_OUT_U,
    MEM_IN_U,
    MEM_IN_SALT,
    MEM_IN_S_ROW_FIRST,
    MEM_IN_B_COL_FIRST,
    MEM_OUT_B_COL_FIRST,
    MEM_IN_OP_B_PLEQ_S_TIMES_IN_AT,
    MEM_OP_ERASE1
  } mem_cmd_e;

  typedef enum logic [3:0] {
    EXP_GENERIC,
    EXP_KI_BYTE,
    EXP_K_SINGLE,
    EXP_K_LONG_IN,
    EXP_K_LONG_OUT,
    EXP_K_NO_OVERLAP,
    EXP_M,
    EXP_GEN_A_K_OUT
  } exp_kind_e;

  // Source of the hash unit input stream
  typedef enum logic [1:0] {
    KI_FORWARD,
    KI_SEND_BYTE,
    KI_SEND_ZEROS
  } k_in_mode_e;

  typedef struct packed {
    exp_kind_e kind;
    logic      k_is_last;
    logic      k_is_sampled;
    param_t    param;
    mem_cmd_e  mem_cmd;
    logic      is_pack;
    hub_mask_t h_dst;
    hub_mask_t h_src;
  } step_item_t;

  typedef struct packed {
    logic k;
    logic k_in;
    logic k_out;
    logic o_in;
    logic o_out;
    logic m;
    logic s;
  } core_which_t;

  typedef struct packed {
    word_cnt_t  o_in_words;
    word_cnt_t  o_out_words;
    logic [7:0] k_in_byte;
    logic       k_in_not_last;
    k_in_mode_e k_in_mode;
    logic       k_out_not_last;
    logic       k_out_sampled;
    hub_mask_t  h_dst;
    hub_mask_t  h_src;
    logic       is_pack;
    mem_cmd_e   mem_cmd;
    k_mode_t    k_mode;
    param_t     k_count;
    logic       k_en;
    logic       s;
  } core_cmd_t;

endpackage

`default_nettype wire

/* src/kem_cmd_pkg.sv */
`default_nettype none

package kem_cmd_pkg;

  // Commands a host may issue
  typedef enum logic [2:0] {
    CMD_KEYGEN,
    CMD_ADD_ENTROPY,
    CMD_SETUP_TEST
  } host_cmd_e;

  // Phases handed from the phase sequencer to the flattener
  typedef enum logic [2:0] {
    PH_GEN_A,
    PH_KEYGEN_PRNG,
    PH_KEYGEN_MID,
    PH_KEYGEN_POST_GEN_A,
    PH_ADD_ENTROPY,
    PH_SETUP_TEST
  } phase_e;

  // Step tables known to the step sequencer
  typedef enum logic [3:0] {
    TBL_GEN_A_ITER,
    TBL_KEYGEN_PRNG,
    TBL_KEYGEN_NO_PRNG,
    TBL_KEYGEN_MID,
    TBL_KEYGEN_POST_GEN_A,
    TBL_SETUP_TEST,
    TBL_ADD_ENTROPY
  } step_table_e;

  typedef struct packed {
    phase_e phase;
    logic   is_test;
  } phase_item_t;

endpackage

`default_nettype wire

/* src/frodo_config.svh */
`ifndef FRODO_CONFIG_SVH
`define FRODO_CONFIG_SVH

// Matrix row index carried from the flattener to the step tables
`define FRODO_ROW_W 16

// Length field of a step item, also the hash unit block count
`define FRODO_PARAM_W 9

// Longest step table, keygen_prng and keygen_mid
`define FRODO_MAX_STEPS 10

// Rows of matrix A for the largest set, 640 and 976 also work
`define FRODO_GENA_ROWS 1344

// Words per hub move between the hash unit and the outer port
`define FRODO_KOUT_WORDS 4
`define FRODO_KIN_WORDS 16

`endif
